//--- common/soc_pkg.sv
package soc_pkg;

  // address windows, each top address is exclusive.
  localparam logic [31:0] clint_base_addr = 32'h0200_0000;
  localparam logic [31:0] clint_top_addr  = 32'h0201_0000;
  localparam logic [31:0] uart_base_addr  = 32'h1000_0000;
  localparam logic [31:0] uart_top_addr   = 32'h1000_0010;
  localparam logic [31:0] bram_base_addr  = 32'h8000_0000;
  // sized for the default RAM of 1024 words.
  localparam logic [31:0] bram_top_addr   = 32'h8000_1000;

  localparam logic [31:0] uart_data_off   = 32'h0000_0000;
  localparam logic [31:0] uart_status_off = 32'h0000_0004;

  // mtimecmp and mtime are 64 bits, the high word sits 4 bytes above the low word.
  localparam logic [31:0] clint_msip_off     = 32'h0000_0000;
  localparam logic [31:0] clint_mtimecmp_off = 32'h0000_4000;
  localparam logic [31:0] clint_mtime_off    = 32'h0000_bff8;

  typedef enum logic [1:0] {tgt_none, tgt_bram, tgt_uart, tgt_clint} target_e;

  typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} uart_state_e;

  // byte-wise merge of a write into a stored word under its strobes.
  function automatic logic [31:0] strb_merge(input logic [31:0] old_word,
                                             input logic [31:0] wdata,
                                             input logic [3:0]  wstrb);
    logic [31:0] merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) begin
        merged[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

//--- interconnect/mem_interconnect.sv
`timescale 1ns/1ps

module mem_interconnect import soc_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        imem_valid_i,
  input  logic        imem_instr_i,
  input  logic [31:0] imem_addr_i,
  input  logic [31:0] imem_wdata_i,
  input  logic [3:0]  imem_wstrb_i,
  output logic [31:0] imem_rdata_o,
  output logic        imem_ready_o,
  input  logic        dmem_valid_i,
  input  logic        dmem_instr_i,
  input  logic [31:0] dmem_addr_i,
  input  logic [31:0] dmem_wdata_i,
  input  logic [3:0]  dmem_wstrb_i,
  output logic [31:0] dmem_rdata_o,
  output logic        dmem_ready_o,
  output logic        bram_valid_o,
  output logic        bram_wen_o,
  output logic        bram_instr_o,
  output logic [31:0] bram_addr_o,
  output logic [31:0] bram_wdata_o,
  output logic [3:0]  bram_wstrb_o,
  input  logic [31:0] bram_rdata_i,
  input  logic        bram_ready_i,
  output logic        uart_valid_o,
  output logic        uart_instr_o,
  output logic [31:0] uart_addr_o,
  output logic [31:0] uart_wdata_o,
  output logic [3:0]  uart_wstrb_o,
  input  logic [31:0] uart_rdata_i,
  input  logic        uart_ready_i,
  output logic        clint_valid_o,
  output logic        clint_instr_o,
  output logic [31:0] clint_addr_o,
  output logic [31:0] clint_wdata_o,
  output logic [3:0]  clint_wstrb_o,
  input  logic [31:0] clint_rdata_i,
  input  logic        clint_ready_i
);

  target_e     imem_tgt, dmem_tgt;
  target_e     imem_route, dmem_route;
  logic [31:0] imem_off, dmem_off;
  logic        bram_sel_d, uart_sel_d, clint_sel_d;
  // owner bits are set when the data port holds the target.
  logic        bram_owner_r, uart_owner_r, clint_owner_r;
  logic        imem_unm_r, dmem_unm_r;
  logic [2:0]  imem_hit, dmem_hit;

  function automatic target_e decode(input logic [31:0] addr);
    target_e t;
    if (addr >= clint_base_addr && addr < clint_top_addr) begin
      t = tgt_clint;
    end else if (addr >= uart_base_addr && addr < uart_top_addr) begin
      t = tgt_uart;
    end else if (addr >= bram_base_addr && addr < bram_top_addr) begin
      t = tgt_bram;
    end else begin
      t = tgt_none;
    end
    return t;
  endfunction

  function automatic logic [31:0] base_of(input target_e t);
    logic [31:0] b;
    case (t)
      tgt_bram:  b = bram_base_addr;
      tgt_uart:  b = uart_base_addr;
      tgt_clint: b = clint_base_addr;
      default:   b = '0;
    endcase
    return b;
  endfunction

  assign imem_tgt   = decode(imem_addr_i);
  assign dmem_tgt   = decode(dmem_addr_i);
  assign imem_off   = imem_addr_i - base_of(imem_tgt);
  assign dmem_off   = dmem_addr_i - base_of(dmem_tgt);
  assign dmem_route = dmem_valid_i ? dmem_tgt : tgt_none;

  always_comb begin
    imem_route = imem_valid_i ? imem_tgt : tgt_none;
    // the data port wins a shared target. the fetch keeps valid high and waits.
    if (imem_route == dmem_route) begin
      imem_route = tgt_none;
    end
  end

  assign bram_sel_d    = (dmem_route == tgt_bram);
  assign bram_valid_o  = bram_sel_d || (imem_route == tgt_bram);
  assign bram_instr_o  = bram_sel_d ? dmem_instr_i : imem_instr_i;
  assign bram_addr_o   = bram_sel_d ? dmem_off : imem_off;
  assign bram_wdata_o  = bram_sel_d ? dmem_wdata_i : imem_wdata_i;
  assign bram_wstrb_o  = bram_sel_d ? dmem_wstrb_i : imem_wstrb_i;
  assign bram_wen_o    = bram_valid_o && (|bram_wstrb_o);

  assign uart_sel_d    = (dmem_route == tgt_uart);
  assign uart_valid_o  = uart_sel_d || (imem_route == tgt_uart);
  assign uart_instr_o  = uart_sel_d ? dmem_instr_i : imem_instr_i;
  assign uart_addr_o   = uart_sel_d ? dmem_off : imem_off;
  assign uart_wdata_o  = uart_sel_d ? dmem_wdata_i : imem_wdata_i;
  assign uart_wstrb_o  = uart_sel_d ? dmem_wstrb_i : imem_wstrb_i;

  assign clint_sel_d   = (dmem_route == tgt_clint);
  assign clint_valid_o = clint_sel_d || (imem_route == tgt_clint);
  assign clint_instr_o = clint_sel_d ? dmem_instr_i : imem_instr_i;
  assign clint_addr_o  = clint_sel_d ? dmem_off : imem_off;
  assign clint_wdata_o = clint_sel_d ? dmem_wdata_i : imem_wdata_i;
  assign clint_wstrb_o = clint_sel_d ? dmem_wstrb_i : imem_wstrb_i;

  // the owner only changes when the target can take the request.
  always_ff @(posedge clk) begin
    if (!rst) begin
      bram_owner_r  <= 1'b0;
      uart_owner_r  <= 1'b0;
      clint_owner_r <= 1'b0;
      imem_unm_r    <= 1'b0;
      dmem_unm_r    <= 1'b0;
    end else begin
      if (bram_valid_o && !bram_ready_i) begin
        bram_owner_r <= bram_sel_d;
      end
      if (uart_valid_o && !uart_ready_i) begin
        uart_owner_r <= uart_sel_d;
      end
      if (clint_valid_o && !clint_ready_i) begin
        clint_owner_r <= clint_sel_d;
      end
      imem_unm_r <= imem_valid_i && (imem_tgt == tgt_none) && !imem_unm_r;
      dmem_unm_r <= dmem_valid_i && (dmem_tgt == tgt_none) && !dmem_unm_r;
    end
  end

  assign imem_hit = {clint_ready_i && !clint_owner_r, uart_ready_i && !uart_owner_r,
                     bram_ready_i && !bram_owner_r};
  assign dmem_hit = {clint_ready_i && clint_owner_r, uart_ready_i && uart_owner_r,
                     bram_ready_i && bram_owner_r};

  // an unmapped access is answered here with zero data.
  assign imem_ready_o = (|imem_hit) || imem_unm_r;
  assign dmem_ready_o = (|dmem_hit) || dmem_unm_r;
  assign imem_rdata_o = ({32{imem_hit[0]}} & bram_rdata_i)
                      | ({32{imem_hit[1]}} & uart_rdata_i)
                      | ({32{imem_hit[2]}} & clint_rdata_i);
  assign dmem_rdata_o = ({32{dmem_hit[0]}} & bram_rdata_i)
                      | ({32{dmem_hit[1]}} & uart_rdata_i)
                      | ({32{dmem_hit[2]}} & clint_rdata_i);

endmodule

//--- src/bram.sv
`timescale 1ns/1ps

module bram import soc_pkg::*; #(
  parameter int BRAM_DEPTH = 10
) (
  input  logic                  clk,
  input  logic                  wen_i,
  input  logic [BRAM_DEPTH-1:0] addr_i,
  input  logic [31:0]           wdata_i,
  input  logic [3:0]            wstrb_i,
  input  logic                  valid_i,
  output logic [31:0]           rdata_o,
  output logic                  ready_o
);

  logic [31:0] mem [2**BRAM_DEPTH];
  logic        take;

  // the master holds valid through the ready cycle, so that cycle is not a new request.
  assign take = valid_i && !ready_o;

  always_ff @(posedge clk) begin
    ready_o <= take;
    if (take) begin
      rdata_o <= mem[addr_i];
      if (wen_i) begin
        mem[addr_i] <= strb_merge(mem[addr_i], wdata_i, wstrb_i);
      end
    end
  end

endmodule

//--- uart/uart.sv
`timescale 1ns/1ps

module uart import soc_pkg::*; #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        valid_i,
  input  logic        instr_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  wstrb_i,
  output logic [31:0] rdata_o,
  output logic        ready_o,
  input  logic        rx_i,
  output logic        tx_o
);

  localparam int               cnt_w    = $clog2(CLKS_PER_BIT + 1);
  localparam logic [cnt_w-1:0] bit_last = cnt_w'(CLKS_PER_BIT - 1);
  localparam logic [cnt_w-1:0] bit_half = cnt_w'((CLKS_PER_BIT - 1) / 2);

  uart_state_e      tx_state, rx_state;
  logic [cnt_w-1:0] tx_cnt, rx_cnt;
  logic [2:0]       tx_idx, rx_idx;
  logic [7:0]       tx_shift, rx_shift, rx_data;
  logic             rx_meta, rx_sync, rx_valid;
  logic             tx_tick, rx_tick;
  logic             take, data_acc, tx_load, rx_clear;

  assign take     = valid_i && !ready_o;
  // only data accesses have side effects. a fetch just reads.
  assign data_acc = take && !instr_i;
  assign tx_load  = data_acc && (|wstrb_i) && (addr_i == uart_data_off)
                    && (tx_state == st_idle);
  assign rx_clear = data_acc && (wstrb_i == 4'b0) && (addr_i == uart_data_off);

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready_o <= 1'b0;
    end else begin
      ready_o <= take;
    end
    if (take) begin
      case (addr_i)
        uart_data_off:   rdata_o <= {24'b0, rx_data};
        uart_status_off: rdata_o <= {30'b0, rx_valid, tx_state != st_idle};
        default:         rdata_o <= '0;
      endcase
    end
  end

  assign tx_tick = (tx_cnt == bit_last);

  always_ff @(posedge clk) begin
    if (!rst) begin
      tx_state <= st_idle;
      tx_cnt   <= '0;
      tx_idx   <= '0;
      tx_o     <= 1'b1;
    end else begin
      tx_cnt <= (tx_state == st_idle || tx_tick) ? '0 : tx_cnt + 1'b1;
      case (tx_state)
        st_idle: begin
          if (tx_load) begin
            tx_shift <= wdata_i[7:0];
            tx_o     <= 1'b0;
            tx_state <= st_start;
          end
        end
        st_start: begin
          if (tx_tick) begin
            tx_idx   <= '0;
            tx_o     <= tx_shift[0];
            tx_state <= st_data;
          end
        end
        st_data: begin
          if (tx_tick) begin
            tx_idx   <= tx_idx + 1'b1;
            tx_shift <= {1'b0, tx_shift[7:1]};
            tx_o     <= (tx_idx == 3'd7) ? 1'b1 : tx_shift[1];
            if (tx_idx == 3'd7) begin
              tx_state <= st_stop;
            end
          end
        end
        default: begin
          if (tx_tick) begin
            tx_state <= st_idle;
          end
        end
      endcase
    end
  end

  // the start bit waits half a bit, so every later sample lands mid-bit.
  assign rx_tick = (rx_cnt == ((rx_state == st_start) ? bit_half : bit_last));

  always_ff @(posedge clk) begin
    if (!rst) begin
      rx_meta  <= 1'b1;
      rx_sync  <= 1'b1;
      rx_state <= st_idle;
      rx_cnt   <= '0;
      rx_idx   <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
      rx_cnt  <= (rx_state == st_idle || rx_tick) ? '0 : rx_cnt + 1'b1;
      if (rx_clear) begin
        rx_valid <= 1'b0;
      end
      case (rx_state)
        st_idle: begin
          if (!rx_sync) begin
            rx_state <= st_start;
          end
        end
        st_start: begin
          if (rx_tick) begin
            rx_idx   <= '0;
            rx_state <= rx_sync ? st_idle : st_data;
          end
        end
        st_data: begin
          if (rx_tick) begin
            rx_shift <= {rx_sync, rx_shift[7:1]};
            rx_idx   <= rx_idx + 1'b1;
            if (rx_idx == 3'd7) begin
              rx_state <= st_stop;
            end
          end
        end
        default: begin
          if (rx_tick) begin
            // a frame without its stop bit is dropped.
            if (rx_sync) begin
              rx_data  <= rx_shift;
              rx_valid <= 1'b1;
            end
            rx_state <= st_idle;
          end
        end
      endcase
    end
  end

endmodule

//--- clint/clint.sv
`timescale 1ns/1ps

module clint import soc_pkg::*; #(
  parameter int RTC_DIV = 4
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        valid_i,
  input  logic        instr_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  wstrb_i,
  output logic [31:0] rdata_o,
  output logic        ready_o,
  output logic        msip_o,
  output logic        mtip_o
);

  localparam int               div_w    = $clog2(RTC_DIV + 1);
  localparam logic [div_w-1:0] div_last = div_w'(RTC_DIV - 1);

  logic [div_w-1:0] div_cnt;
  logic [63:0]      mtime, mtimecmp;
  logic             tick, take, wr;

  assign tick = (div_cnt == div_last);
  assign take = valid_i && !ready_o;
  assign wr   = take && !instr_i && (|wstrb_i);

  always_ff @(posedge clk) begin
    if (!rst) begin
      div_cnt  <= '0;
      mtime    <= '0;
      mtimecmp <= '1;
      msip_o   <= 1'b0;
      mtip_o   <= 1'b0;
      ready_o  <= 1'b0;
    end else begin
      ready_o <= take;
      div_cnt <= tick ? '0 : div_cnt + 1'b1;
      mtip_o  <= (mtime >= mtimecmp);
      if (tick) begin
        mtime <= mtime + 64'd1;
      end
      // a software write to mtime overrides the tick in the same cycle.
      if (wr) begin
        case (addr_i)
          clint_msip_off:
            msip_o <= wstrb_i[0] ? wdata_i[0] : msip_o;
          clint_mtimecmp_off:
            mtimecmp[31:0] <= strb_merge(mtimecmp[31:0], wdata_i, wstrb_i);
          clint_mtimecmp_off + 32'd4:
            mtimecmp[63:32] <= strb_merge(mtimecmp[63:32], wdata_i, wstrb_i);
          clint_mtime_off:
            mtime[31:0] <= strb_merge(mtime[31:0], wdata_i, wstrb_i);
          clint_mtime_off + 32'd4:
            mtime[63:32] <= strb_merge(mtime[63:32], wdata_i, wstrb_i);
          default: begin
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      case (addr_i)
        clint_msip_off:             rdata_o <= {31'b0, msip_o};
        clint_mtimecmp_off:         rdata_o <= mtimecmp[31:0];
        clint_mtimecmp_off + 32'd4: rdata_o <= mtimecmp[63:32];
        clint_mtime_off:            rdata_o <= mtime[31:0];
        clint_mtime_off + 32'd4:    rdata_o <= mtime[63:32];
        default:                    rdata_o <= '0;
      endcase
    end
  end

endmodule

//--- src/soc_bus.sv
`timescale 1ns/1ps

module soc_bus #(
  parameter int BRAM_DEPTH   = 10,
  parameter int CLKS_PER_BIT = 8,
  parameter int RTC_DIV      = 4
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        imem_valid_i,
  input  logic        imem_instr_i,
  input  logic [31:0] imem_addr_i,
  input  logic [31:0] imem_wdata_i,
  input  logic [3:0]  imem_wstrb_i,
  output logic [31:0] imem_rdata_o,
  output logic        imem_ready_o,
  input  logic        dmem_valid_i,
  input  logic        dmem_instr_i,
  input  logic [31:0] dmem_addr_i,
  input  logic [31:0] dmem_wdata_i,
  input  logic [3:0]  dmem_wstrb_i,
  output logic [31:0] dmem_rdata_o,
  output logic        dmem_ready_o,
  input  logic        rx_i,
  output logic        tx_o,
  output logic        msip_o,
  output logic        mtip_o
);

  logic        bram_valid, bram_wen, bram_ready;
  logic [31:0] bram_addr, bram_wdata, bram_rdata;
  logic [3:0]  bram_wstrb;
  logic        uart_valid, uart_instr, uart_ready;
  logic [31:0] uart_addr, uart_wdata, uart_rdata;
  logic [3:0]  uart_wstrb;
  logic        clint_valid, clint_instr, clint_ready;
  logic [31:0] clint_addr, clint_wdata, clint_rdata;
  logic [3:0]  clint_wstrb;

  // the master ports connect by name.
  mem_interconnect u_interconnect (
    .*,
    .bram_valid_o  (bram_valid),
    .bram_wen_o    (bram_wen),
    .bram_instr_o  (),
    .bram_addr_o   (bram_addr),
    .bram_wdata_o  (bram_wdata),
    .bram_wstrb_o  (bram_wstrb),
    .bram_rdata_i  (bram_rdata),
    .bram_ready_i  (bram_ready),
    .uart_valid_o  (uart_valid),
    .uart_instr_o  (uart_instr),
    .uart_addr_o   (uart_addr),
    .uart_wdata_o  (uart_wdata),
    .uart_wstrb_o  (uart_wstrb),
    .uart_rdata_i  (uart_rdata),
    .uart_ready_i  (uart_ready),
    .clint_valid_o (clint_valid),
    .clint_instr_o (clint_instr),
    .clint_addr_o  (clint_addr),
    .clint_wdata_o (clint_wdata),
    .clint_wstrb_o (clint_wstrb),
    .clint_rdata_i (clint_rdata),
    .clint_ready_i (clint_ready)
  );

  // the RAM is word addressed.
  bram #(.BRAM_DEPTH(BRAM_DEPTH)) u_bram (
    .clk     (clk),
    .wen_i   (bram_wen),
    .addr_i  (bram_addr[BRAM_DEPTH+1:2]),
    .wdata_i (bram_wdata),
    .wstrb_i (bram_wstrb),
    .valid_i (bram_valid),
    .rdata_o (bram_rdata),
    .ready_o (bram_ready)
  );

  uart #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart (
    .clk     (clk),
    .rst     (rst),
    .valid_i (uart_valid),
    .instr_i (uart_instr),
    .addr_i  (uart_addr),
    .wdata_i (uart_wdata),
    .wstrb_i (uart_wstrb),
    .rdata_o (uart_rdata),
    .ready_o (uart_ready),
    .rx_i    (rx_i),
    .tx_o    (tx_o)
  );

  clint #(.RTC_DIV(RTC_DIV)) u_clint (
    .clk     (clk),
    .rst     (rst),
    .valid_i (clint_valid),
    .instr_i (clint_instr),
    .addr_i  (clint_addr),
    .wdata_i (clint_wdata),
    .wstrb_i (clint_wstrb),
    .rdata_o (clint_rdata),
    .ready_o (clint_ready),
    .msip_o  (msip_o),
    .mtip_o  (mtip_o)
  );

endmodule

//--- verif/soc_bus_sva.sv
`timescale 1ns/1ps

module soc_bus_sva import soc_pkg::*; (
  input logic        clk,
  input logic        rst,
  input logic        imem_valid_i,
  input logic        dmem_valid_i,
  input target_e     imem_tgt_i,
  input target_e     dmem_tgt_i,
  input logic        imem_ready_i,
  input logic        dmem_ready_i,
  input logic        bram_valid_i,
  input logic        bram_ready_i,
  input logic        uart_valid_i,
  input logic        uart_ready_i,
  input logic        clint_valid_i,
  input logic        clint_ready_i,
  input uart_state_e tx_state_i,
  input logic        tx_i
);

  int fail_count = 0;

  // when both ports want one free target, only the data port is answered next cycle.
  route_excl: assert property (@(posedge clk) disable iff (!rst)
    imem_valid_i && dmem_valid_i && imem_tgt_i == dmem_tgt_i && dmem_tgt_i != tgt_none
    && !imem_ready_i && !dmem_ready_i |=> dmem_ready_i && !imem_ready_i)
    else begin
      $error("both ports routed to the same target");
      fail_count++;
    end

  // a target answers exactly one cycle after it took a request.
  bram_resp: assert property (@(posedge clk) disable iff (!rst)
    bram_ready_i |-> $past(bram_valid_i && !bram_ready_i))
    else begin
      $error("bram ready without a request one cycle earlier");
      fail_count++;
    end

  uart_resp: assert property (@(posedge clk) disable iff (!rst)
    uart_ready_i |-> $past(uart_valid_i && !uart_ready_i))
    else begin
      $error("uart ready without a request one cycle earlier");
      fail_count++;
    end

  clint_resp: assert property (@(posedge clk) disable iff (!rst)
    clint_ready_i |-> $past(clint_valid_i && !clint_ready_i))
    else begin
      $error("clint ready without a request one cycle earlier");
      fail_count++;
    end

  tx_idle_high: assert property (@(posedge clk) disable iff (!rst)
    tx_state_i == st_idle |-> tx_i)
    else begin
      $error("tx line low while the transmitter is idle");
      fail_count++;
    end

endmodule

bind soc_bus soc_bus_sva u_sva (
  .clk           (clk),
  .rst           (rst),
  .imem_valid_i  (imem_valid_i),
  .dmem_valid_i  (dmem_valid_i),
  .imem_tgt_i    (u_interconnect.imem_tgt),
  .dmem_tgt_i    (u_interconnect.dmem_tgt),
  .imem_ready_i  (imem_ready_o),
  .dmem_ready_i  (dmem_ready_o),
  .bram_valid_i  (bram_valid),
  .bram_ready_i  (bram_ready),
  .uart_valid_i  (uart_valid),
  .uart_ready_i  (uart_ready),
  .clint_valid_i (clint_valid),
  .clint_ready_i (clint_ready),
  .tx_state_i    (u_uart.tx_state),
  .tx_i          (tx_o)
);

//--- verif/tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus import soc_pkg::*; ();

  localparam int    clks_per_bit = 8;
  localparam int    hs_limit     = 16;
  localparam int    poll_limit   = 200;
  localparam int    mtip_limit   = 400;
  localparam string trace_path   = "verif/soc_trace.txt";

  logic        clk, rst;
  logic        imem_valid, imem_instr, dmem_valid, dmem_instr;
  logic [31:0] imem_addr, imem_wdata, dmem_addr, dmem_wdata;
  logic [3:0]  imem_wstrb, dmem_wstrb;
  logic [31:0] imem_rdata, dmem_rdata;
  logic        imem_ready, dmem_ready;
  logic        rx, tx, msip, mtip, loop_en;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;

  // the transmitter feeds its own receiver once reset is released.
  assign rx = loop_en ? tx : 1'b1;

  soc_bus #(.BRAM_DEPTH(10), .CLKS_PER_BIT(clks_per_bit), .RTC_DIV(4)) DUT (
    .clk          (clk),
    .rst          (rst),
    .imem_valid_i (imem_valid),
    .imem_instr_i (imem_instr),
    .imem_addr_i  (imem_addr),
    .imem_wdata_i (imem_wdata),
    .imem_wstrb_i (imem_wstrb),
    .imem_rdata_o (imem_rdata),
    .imem_ready_o (imem_ready),
    .dmem_valid_i (dmem_valid),
    .dmem_instr_i (dmem_instr),
    .dmem_addr_i  (dmem_addr),
    .dmem_wdata_i (dmem_wdata),
    .dmem_wstrb_i (dmem_wstrb),
    .dmem_rdata_o (dmem_rdata),
    .dmem_ready_o (dmem_ready),
    .rx_i         (rx),
    .tx_o         (tx),
    .msip_o       (msip),
    .mtip_o       (mtip)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAIL %s: expected 0x%08h, actual 0x%08h", name, expected, actual));
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      abort_run($sformatf("ERROR: timeout, trace not finished in %0d cycles", cycle_limit));
    end
    if (DUT.u_sva.fail_count != 0) begin
      abort_run("ERROR: a bus protocol assertion failed");
    end
  end

  // one handshake on either port, with a bound on the wait for ready.
  task automatic bus_access(input bit fetch_port, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] wstrb,
                            output logic [31:0] rdata);
    int   waited;
    logic got;
    @(negedge clk);
    if (fetch_port) begin
      imem_valid = 1'b1;
      imem_addr  = addr;
      imem_wdata = wdata;
      imem_wstrb = wstrb;
    end else begin
      dmem_valid = 1'b1;
      dmem_addr  = addr;
      dmem_wdata = wdata;
      dmem_wstrb = wstrb;
    end
    waited = 0;
    got = 1'b0;
    while (!got && waited < hs_limit) begin
      @(negedge clk);
      waited++;
      got = fetch_port ? imem_ready : dmem_ready;
    end
    if (!got) begin
      abort_run($sformatf("ERROR: no ready within %0d cycles for address 0x%08h",
                          hs_limit, addr));
    end
    rdata = fetch_port ? imem_rdata : dmem_rdata;
    imem_valid = 1'b0;
    dmem_valid = 1'b0;
  endtask

  // both ports read one address in the same cycle.
  task automatic dual_read(input string name, input logic [31:0] addr,
                           input logic [31:0] exp_val);
    int          n, d_at, i_at;
    logic [31:0] d_data, i_data;
    @(negedge clk);
    dmem_valid = 1'b1;
    dmem_addr  = addr;
    dmem_wstrb = 4'h0;
    imem_valid = 1'b1;
    imem_addr  = addr;
    imem_wstrb = 4'h0;
    n = 0;
    d_at = 0;
    i_at = 0;
    while ((d_at == 0 || i_at == 0) && n < hs_limit) begin
      @(negedge clk);
      n++;
      if (dmem_ready && d_at == 0) begin
        d_at = n;
        d_data = dmem_rdata;
        dmem_valid = 1'b0;
      end
      if (imem_ready && i_at == 0) begin
        i_at = n;
        i_data = imem_rdata;
        imem_valid = 1'b0;
      end
    end
    if (d_at == 0 || i_at == 0) begin
      abort_run("ERROR: the conflicting reads did not both complete");
    end
    check_value({name, "_dmem"}, exp_val, d_data);
    check_value({name, "_imem"}, exp_val, i_data);
    check_value({name, "_gap"}, 32'd2, i_at - d_at);
  endtask

  // returns the next data line of the trace; lines that start with # are skipped.
  task automatic next_entry(input int fd, output bit found, output string tname,
                            output string op, output logic [31:0] addr,
                            output logic [31:0] wdata, output logic [3:0] wstrb,
                            output logic [31:0] exp_val);
    string          line;
    logic [8*32-1:0] name_raw, op_raw;
    int             r;
    bit             at_end;
    found = 1'b0;
    at_end = 1'b0;
    while (!found && !at_end) begin
      name_raw = '0;
      op_raw = '0;
      if ($fgets(line, fd) == 0) begin
        at_end = 1'b1;
      end else begin
        r = $sscanf(line, "%s %s %h %h %h %h", name_raw, op_raw, addr, wdata, wstrb, exp_val);
        tname = $sformatf("%0s", name_raw);
        op = $sformatf("%0s", op_raw);
        if (r == 6) begin
          found = 1'b1;
        end else if (r > 0 && tname != "#") begin
          abort_run({"ERROR: malformed trace line: ", line});
        end
      end
    end
  endtask

  task automatic count_trace(output int lines, output int uart_bytes);
    int          fd;
    bit          found;
    string       tname, op;
    logic [31:0] addr, wdata, exp_val;
    logic [3:0]  wstrb;
    lines = 0;
    uart_bytes = 0;
    fd = $fopen(trace_path, "r");
    if (fd == 0) begin
      abort_run({"ERROR: cannot open the trace file ", trace_path});
    end
    next_entry(fd, found, tname, op, addr, wdata, wstrb, exp_val);
    while (found) begin
      lines++;
      if (op == "write" && addr == uart_base_addr + uart_data_off) begin
        uart_bytes++;
      end
      next_entry(fd, found, tname, op, addr, wdata, wstrb, exp_val);
    end
    $fclose(fd);
  endtask

  task automatic run_entry(input string tname, input string op, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] wstrb,
                           input logic [31:0] exp_val);
    logic [31:0] rdata;
    int          n;
    bit          hit;
    if (op == "write") begin
      bus_access(1'b0, addr, wdata, wstrb, rdata);
    end else if (op == "read") begin
      bus_access(1'b0, addr, 32'h0, 4'h0, rdata);
      check_value(tname, exp_val, rdata);
    end else if (op == "fetch") begin
      bus_access(1'b1, addr, 32'h0, 4'h0, rdata);
      check_value(tname, exp_val, rdata);
    end else if (op == "both") begin
      dual_read(tname, addr, exp_val);
    end else if (op == "atleast") begin
      bus_access(1'b0, addr, 32'h0, 4'h0, rdata);
      if (rdata < exp_val) begin
        check_value(tname, exp_val, rdata);
      end
    end else if (op == "poll") begin
      // wdata is the mask of the status bits that are compared.
      n = 0;
      hit = 1'b0;
      while (!hit && n < poll_limit) begin
        bus_access(1'b0, addr, 32'h0, 4'h0, rdata);
        hit = ((rdata & wdata) == exp_val);
        n++;
      end
      if (!hit) begin
        abort_run($sformatf("ERROR: %s, address 0x%08h never showed 0x%08h in %0d reads",
                            tname, addr, exp_val, poll_limit));
      end
    end else if (op == "wait_mtip") begin
      n = 0;
      while (mtip !== exp_val[0] && n < mtip_limit) begin
        @(negedge clk);
        n++;
      end
      if (mtip !== exp_val[0]) begin
        abort_run($sformatf("ERROR: %s, the timer interrupt did not reach %0d in %0d cycles",
                            tname, exp_val[0], mtip_limit));
      end
    end else if (op == "pins") begin
      check_value(tname, exp_val, {29'b0, tx, msip, mtip});
    end else begin
      abort_run({"ERROR: unknown operation in the trace: ", op});
    end
  endtask

  initial begin
    int          lines, uart_bytes, fd;
    bit          found;
    string       tname, op;
    logic [31:0] addr, wdata, exp_val;
    logic [3:0]  wstrb;
    rst = 1'b0;
    loop_en = 1'b0;
    imem_valid = 1'b0;
    imem_instr = 1'b1;
    imem_addr = 32'h0;
    imem_wdata = 32'h0;
    imem_wstrb = 4'h0;
    dmem_valid = 1'b0;
    dmem_instr = 1'b0;
    dmem_addr = 32'h0;
    dmem_wdata = 32'h0;
    dmem_wstrb = 4'h0;
    count_trace(lines, uart_bytes);
    cycle_limit = 16 + 40 * lines + 12 * clks_per_bit * uart_bytes;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    loop_en = 1'b1;
    @(negedge clk);
    check_value("reset_ready", 32'h0, {30'b0, imem_ready, dmem_ready});
    check_value("reset_pins", 32'h4, {29'b0, tx, msip, mtip});
    fd = $fopen(trace_path, "r");
    if (fd == 0) begin
      abort_run({"ERROR: cannot open the trace file ", trace_path});
    end
    next_entry(fd, found, tname, op, addr, wdata, wstrb, exp_val);
    while (found) begin
      run_entry(tname, op, addr, wdata, wstrb, exp_val);
      next_entry(fd, found, tname, op, addr, wdata, wstrb, exp_val);
    end
    $fclose(fd);
    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- verif/soc_trace.txt
# columns: test op addr wdata wstrb expect, numbers in hex
# ops: write read fetch both poll wait_mtip pins atleast, poll takes its mask from wdata
bram_full      write      80000010 11223344 f 00000000
bram_full_rd   read       80000010 00000000 0 11223344
bram_strb_5    write      80000010 aabbccdd 5 00000000
bram_strb_8    write      80000010 99000000 8 00000000
bram_merge     read       80000010 00000000 0 99bb33dd
bram_fetch     fetch      80000010 00000000 0 99bb33dd
bram_last      write      80000ffc cafef00d f 00000000
bram_last_rd   read       80000ffc 00000000 0 cafef00d
conflict       both       80000010 00000000 0 99bb33dd
unmapped_rd    read       40000000 00000000 0 00000000
unmapped_if    fetch      40000000 00000000 0 00000000
unmapped_wr    write      80001010 deadbeef f 00000000
unmapped_keep  read       80000010 00000000 0 99bb33dd
uart_tx_a5     write      10000000 000000a5 1 00000000
uart_rx_wait   poll       10000004 00000002 0 00000002
uart_rx_a5     read       10000000 00000000 0 000000a5
uart_rx_clr    poll       10000004 00000002 0 00000000
uart_tx_idle   poll       10000004 00000001 0 00000000
uart_tx_3c     write      10000000 0000003c 1 00000000
uart_rx_wait2  poll       10000004 00000002 0 00000002
uart_rx_3c     read       10000000 00000000 0 0000003c
msip_set       write      02000000 00000001 1 00000000
msip_rd        read       02000000 00000000 0 00000001
msip_pin       pins       00000000 00000000 0 00000006
msip_clr       write      02000000 00000000 1 00000000
cmp_hi_zero    write      02004004 00000000 f 00000000
mtime_zero     write      0200bff8 00000000 f 00000000
cmp_lo_small   write      02004000 00000010 f 00000000
mtip_rise      wait_mtip  00000000 00000000 0 00000001
mtime_past     atleast    0200bff8 00000000 0 00000010
cmp_lo_ones    write      02004000 ffffffff f 00000000
mtip_fall      wait_mtip  00000000 00000000 0 00000000
cmp_hi_ones    write      02004004 ffffffff f 00000000
clint_pins     pins       00000000 00000000 0 00000004

//--- compile.f
common/soc_pkg.sv
interconnect/mem_interconnect.sv
src/bram.sv
uart/uart.sv
clint/clint.sv
src/soc_bus.sv
verif/soc_bus_sva.sv
verif/tb_soc_bus.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc_bus
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run the trace"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
